/* filelist.f */
+incdir+test
common/vram_pkg.sv
vram/vram.sv
verilog/vram_arbiter.sv
verilog/host_regs.sv
verilog/line_fetch.sv
verilog/vid_mem_top.sv
test/tb_vid_mem.sv

/* Makefile */
# Verilator build and run for the video memory testbench

VERILATOR ?= verilator
TOP       ?= tb_vid_mem
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator status is ignored, the log decides pass or fail
run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tb_apb_tasks.svh */
// apb transfer tasks with pready timeout, included in the testbench module
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

localparam int APB_TIMEOUT = 64;    // cycles allowed for pready

time done_time;     // posedge where the last transfer saw pready

// setup cycle, then access cycles until pready
task automatic apb_access(input logic wr, input reg_sel_t idx, input vram_word_t wdata,
                          output vram_word_t rdata, output logic err);
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    rdata  = '0;
    err    = 1'b0;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = {3'b000, idx, 2'b00};
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    while (!done && waited < APB_TIMEOUT) begin
        @(posedge clk);
        waited++;
        if (pready) begin
            done      = 1'b1;
            rdata     = prdata;
            err       = pslverr;
            done_time = $time;
        end
    end
    assert (done) else fail_text("APB transfer got no pready within the timeout");
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
endtask

task automatic apb_write(input reg_sel_t idx, input vram_word_t wdata);
    vram_word_t rd_dummy;
    logic       err;
    apb_access(1'b1, idx, wdata, rd_dummy, err);
    assert (!err) else fail_text("pslverr raised on a register write");
endtask

task automatic apb_read(input reg_sel_t idx, output vram_word_t rdata, output logic err);
    apb_access(1'b0, idx, 16'h0000, rdata, err);
endtask

`endif

/* test/tb_vid_mem.sv */
// testbench for vid_mem_top with lcg stimulus, shadow vram model and assertion checks
module tb_vid_mem;

    import vram_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int PIX_TIMEOUT = 16;    // cycles allowed before the first pixel

    logic                  clk;
    logic                  reset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    vram_word_t            pwdata;
    vram_word_t            prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  line_start;
    logic                  pix_valid;
    vram_word_t            pix_data;

    logic [31:0] lcg_state;
    vram_word_t  shadow [0:VRAM_WORDS-1];   // expected vram contents
    vram_addr_t  model_wr_addr;
    vram_addr_t  model_rd_addr;
    vram_addr_t  model_incr;
    vram_mask_t  model_mask;
    time         last_pix_time;

    vid_mem_top DUT (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .line_start (line_start),
        .pix_valid  (pix_valid),
        .pix_data   (pix_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_text(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic fail_value(input string name, input vram_word_t got, input vram_word_t exp);
        fail_text($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    `include "tb_apb_tasks.svh"

    function automatic vram_word_t rand16();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];    // upper bits are the better ones
    endfunction

    // nibble n of the mask guards data bits 4n+3..4n
    function automatic void model_write(input vram_addr_t addr, input vram_word_t data,
                                        input vram_mask_t mask);
        for (int n = 0; n < NIBBLES; n++) begin
            if (mask[n]) shadow[addr][4*n +: 4] = data[4*n +: 4];
        end
    endfunction

    task automatic set_reg(input reg_sel_t idx, input vram_word_t val);
        apb_write(idx, val);
        case (idx)
            REG_WR_ADDR: model_wr_addr = val;
            REG_RD_ADDR: model_rd_addr = val;
            REG_INCR:    model_incr    = val;
            REG_WR_MASK: model_mask    = val[NIBBLES-1:0];
            default: ;
        endcase
    endtask

    task automatic reg_check(input reg_sel_t idx, input vram_word_t exp);
        vram_word_t got;
        logic       err;
        apb_read(idx, got, err);
        assert (!err) else fail_text("pslverr raised on a mapped register read");
        assert (got === exp) else fail_value("prdata", got, exp);
    endtask

    task automatic data_write(input vram_word_t val);
        apb_write(REG_DATA, val);
        model_write(model_wr_addr, val, model_mask);
        model_wr_addr = model_wr_addr + model_incr;
    endtask

    task automatic data_read_check();
        vram_word_t got;
        logic       err;
        apb_read(REG_DATA, got, err);
        assert (!err) else fail_text("pslverr raised on a data port read");
        assert (got === shadow[model_rd_addr]) else fail_value("prdata", got, shadow[model_rd_addr]);
        model_rd_addr = model_rd_addr + model_incr;
    endtask

    task automatic fill_line(input vram_addr_t base);
        set_reg(REG_WR_ADDR, base);
        for (int k = 0; k < LINE_WORDS; k++) data_write(rand16());
    endtask

    task automatic start_line();
        @(negedge clk);
        line_start = 1'b1;
    endtask

    // entered on the falling edge that raised line_start
    task automatic check_line(input vram_addr_t base);
        int         lat;
        logic       seen;
        vram_addr_t addr;
        lat  = 0;
        seen = 1'b0;
        @(posedge clk);             // fetcher takes the pulse here
        @(negedge clk);
        line_start = 1'b0;
        while (!seen && lat < PIX_TIMEOUT) begin
            @(posedge clk);
            lat++;
            if (pix_valid) seen = 1'b1;
        end
        assert (seen) else fail_text("no pix_valid after line_start");
        assert (lat == 2) else fail_value("pix_valid latency", 16'(lat), 16'd2);
        for (int k = 0; k < LINE_WORDS; k++) begin
            if (k > 0) @(posedge clk);
            addr = base + vram_addr_t'(k);      // wraps at 64k
            assert (pix_valid) else fail_text("pix_valid dropped inside a line");
            assert (pix_data === shadow[addr]) else fail_value("pix_data", pix_data, shadow[addr]);
            last_pix_time = $time;
        end
        @(posedge clk);
        assert (!pix_valid) else fail_text("pix_valid longer than one line");
    endtask

    initial begin
        vram_addr_t start;
        vram_addr_t base;
        vram_addr_t stride;
        vram_word_t got;
        logic       err;

        clk        = 1'b0;
        reset      = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        line_start = 1'b0;
        lcg_state  = 32'hd8f7_aee9;
        model_wr_addr = '0;
        model_rd_addr = '0;
        model_incr    = 16'h0001;
        model_mask    = 4'hf;
        last_pix_time = 0;
        done_time     = 0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        // reset state and register map
        @(posedge clk);
        assert (!pready) else fail_value("pready", 16'(pready), 16'h0);
        assert (!pix_valid) else fail_value("pix_valid", 16'(pix_valid), 16'h0);
        reg_check(REG_WR_ADDR, 16'h0000);
        reg_check(REG_RD_ADDR, 16'h0000);
        reg_check(REG_INCR, 16'h0001);
        reg_check(REG_WR_MASK, 16'h000f);
        reg_check(REG_DISP_BASE, 16'h0000);
        apb_read(reg_sel_t'(3'd6), got, err);
        assert (err) else fail_text("no pslverr on unmapped register index 6");

        // sequential blocks, second one wraps past ffff
        for (int run = 0; run < 2; run++) begin
            start = (run == 0) ? rand16() : 16'hfff0 + (rand16() & 16'h0007);
            set_reg(REG_WR_ADDR, start);
            for (int k = 0; k < 32; k++) data_write(rand16());
            set_reg(REG_RD_ADDR, start);
            for (int k = 0; k < 32; k++) data_read_check();
        end

        // masked overwrite of a known word
        for (int run = 0; run < 4; run++) begin
            start = rand16();
            set_reg(REG_WR_MASK, 16'h000f);
            set_reg(REG_WR_ADDR, start);
            data_write(rand16());
            set_reg(REG_WR_MASK, rand16() & 16'h000f);
            set_reg(REG_WR_ADDR, start);
            data_write(rand16());
            set_reg(REG_RD_ADDR, start);
            data_read_check();
        end
        set_reg(REG_WR_MASK, 16'h000f);

        // plain line fetches, one across the top of vram
        for (int run = 0; run < 2; run++) begin
            base = (run == 0) ? rand16() : 16'hfff8;
            fill_line(base);
            set_reg(REG_DISP_BASE, base);
            start_line();
            check_line(base);
        end

        // host write racing a line fetch
        base = rand16();
        fill_line(base);
        set_reg(REG_DISP_BASE, base);
        start = base + 16'h0100;    // outside the fetched line
        set_reg(REG_WR_ADDR, start);
        start_line();
        fork
            check_line(base);
            data_write(rand16());
        join
        // last grant sits one cycle before its pixel
        assert (done_time >= last_pix_time) else fail_text("host write finished inside the fetch");
        set_reg(REG_RD_ADDR, start);
        data_read_check();

        // stride, read back one address at a time
        stride = rand16() | 16'h0001;
        start  = rand16();
        set_reg(REG_INCR, stride);
        set_reg(REG_WR_ADDR, start);
        for (int k = 0; k < 8; k++) data_write(rand16());
        reg_check(REG_WR_ADDR, start + 16'd8 * stride);
        set_reg(REG_INCR, 16'h0001);
        for (int k = 0; k < 8; k++) begin
            set_reg(REG_RD_ADDR, start + vram_addr_t'(k) * stride);
            data_read_check();
        end

        $display("All tests passed");
        $finish;
    end

endmodule

/* verilog/vid_mem_top.sv */
// video memory top with host registers, line fetcher, arbiter and vram
module vid_mem_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [vram_pkg::APB_ADDR_W-1:0]     paddr,
    input  vram_pkg::vram_word_t                pwdata,
    output vram_pkg::vram_word_t                prdata,
    output logic                                pready,
    output logic                                pslverr,
    input  logic                                line_start,
    output logic                                pix_valid,
    output vram_pkg::vram_word_t                pix_data
);

    import vram_pkg::*;

    vram_req_t  host_req;
    vram_req_t  fetch_req;
    vram_req_t  mem_req;
    vram_word_t rd_data;
    vram_word_t host_rdata;
    vram_word_t fetch_rdata;
    vram_addr_t disp_base;
    logic       host_gnt;
    logic       fetch_gnt;
    logic       host_rvalid;
    logic       fetch_rvalid;

    host_regs u_host_regs (
        .clk         (clk),
        .reset       (reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .host_gnt    (host_gnt),
        .host_rvalid (host_rvalid),
        .host_rdata  (host_rdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .host_req    (host_req),
        .disp_base   (disp_base)
    );

    line_fetch u_line_fetch (
        .clk          (clk),
        .reset        (reset),
        .line_start   (line_start),
        .disp_base    (disp_base),
        .fetch_gnt    (fetch_gnt),
        .fetch_rvalid (fetch_rvalid),
        .fetch_rdata  (fetch_rdata),
        .fetch_req    (fetch_req),
        .pix_valid    (pix_valid),
        .pix_data     (pix_data)
    );

    vram_arbiter u_arbiter (
        .clk          (clk),
        .reset        (reset),
        .host_req     (host_req),
        .fetch_req    (fetch_req),
        .rd_data      (rd_data),
        .mem_req      (mem_req),
        .host_gnt     (host_gnt),
        .fetch_gnt    (fetch_gnt),
        .host_rvalid  (host_rvalid),
        .fetch_rvalid (fetch_rvalid),
        .host_rdata   (host_rdata),
        .fetch_rdata  (fetch_rdata)
    );

    vram u_vram (
        .clk     (clk),
        .mem_req (mem_req),
        .rd_data (rd_data)
    );

endmodule

/* verilog/line_fetch.sv */
// scan line fetcher, reads LINE_WORDS words from the display base and streams them out
module line_fetch (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  line_start,
    input  vram_pkg::vram_addr_t  disp_base,
    input  logic                  fetch_gnt,
    input  logic                  fetch_rvalid,
    input  vram_pkg::vram_word_t  fetch_rdata,
    output vram_pkg::vram_req_t   fetch_req,
    output logic                  pix_valid,
    output vram_pkg::vram_word_t  pix_data
);

    import vram_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_FETCH
    } state_t;

    state_t     state;
    vram_addr_t fetch_addr;     // next word to request
    line_cnt_t  word_cnt;       // requests granted so far
    logic       last_word;

    assign last_word = (word_cnt == line_cnt_t'(LINE_WORDS - 1));

    // read only, one request per cycle while fetching
    always_comb begin
        fetch_req.valid   = (state == ST_FETCH);
        fetch_req.wr_en   = 1'b0;
        fetch_req.wr_mask = '0;
        fetch_req.addr    = fetch_addr;
        fetch_req.data    = '0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            word_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // a line start during a fetch is dropped
                    if (line_start) begin
                        word_cnt <= '0;
                        state    <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (fetch_gnt) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (last_word) state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // address path, base latched at line start
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && line_start) begin
            fetch_addr <= disp_base;
        end else if (state == ST_FETCH && fetch_gnt) begin
            fetch_addr <= fetch_addr + 1'b1;    // wraps at 64k
        end
    end

    // returned words go straight out, no back-pressure
    assign pix_valid = fetch_rvalid;
    assign pix_data  = fetch_rdata;

endmodule

/* verilog/host_regs.sv */
// apb register block with vram data port, address auto increment and display base
module host_regs (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [vram_pkg::APB_ADDR_W-1:0]     paddr,
    input  vram_pkg::vram_word_t                pwdata,
    input  logic                                host_gnt,
    input  logic                                host_rvalid,
    input  vram_pkg::vram_word_t                host_rdata,
    output vram_pkg::vram_word_t                prdata,
    output logic                                pready,
    output logic                                pslverr,
    output vram_pkg::vram_req_t                 host_req,
    output vram_pkg::vram_addr_t                disp_base
);

    import vram_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_GNT,
        ST_WAIT_DATA
    } state_t;

    state_t     state;
    reg_sel_t   reg_sel;
    logic       access;
    logic       data_acc;
    logic       reg_wr;
    logic       wr_done;
    logic       rd_done;

    vram_addr_t wr_addr;
    vram_addr_t rd_addr;
    vram_addr_t incr;
    vram_mask_t wr_mask;

    assign reg_sel  = paddr[4:2];
    assign access   = psel && penable;
    assign data_acc = access && (reg_sel == REG_DATA);

    // plain registers finish in the first access cycle
    assign reg_wr  = (state == ST_IDLE) && access && pwrite && (reg_sel != REG_DATA);
    assign wr_done = (state == ST_WAIT_GNT) && host_gnt && pwrite;
    assign rd_done = (state == ST_WAIT_DATA) && host_rvalid;

    assign pready  = ((state == ST_IDLE) && access && !data_acc) || wr_done || rd_done;
    assign pslverr = (state == ST_IDLE) && access && (reg_sel > REG_DISP_BASE);

    // apb signals are held stable until pready, so the request can follow them
    always_comb begin
        host_req.valid   = (state == ST_WAIT_GNT);
        host_req.wr_en   = pwrite;
        host_req.wr_mask = wr_mask;
        host_req.addr    = pwrite ? wr_addr : rd_addr;
        host_req.data    = pwdata;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (data_acc) state <= ST_WAIT_GNT;
                end
                ST_WAIT_GNT: begin
                    if (host_gnt) state <= pwrite ? ST_IDLE : ST_WAIT_DATA;
                end
                ST_WAIT_DATA: begin
                    if (host_rvalid) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_addr   <= '0;
            rd_addr   <= '0;
            incr      <= INCR_RESET;
            wr_mask   <= WR_MASK_RESET;
            disp_base <= '0;
        end else begin
            if (reg_wr) begin
                case (reg_sel)
                    REG_WR_ADDR:   wr_addr   <= pwdata;
                    REG_RD_ADDR:   rd_addr   <= pwdata;
                    REG_INCR:      incr      <= pwdata;
                    REG_WR_MASK:   wr_mask   <= pwdata[NIBBLES-1:0];
                    REG_DISP_BASE: disp_base <= pwdata;
                    default: ;  // 6 and 7 unmapped
                endcase
            end
            if (wr_done) wr_addr <= wr_addr + incr;   // wraps at 64k
            if (rd_done) rd_addr <= rd_addr + incr;
        end
    end

    always_comb begin
        case (reg_sel)
            REG_WR_ADDR:   prdata = wr_addr;
            REG_RD_ADDR:   prdata = rd_addr;
            REG_DATA:      prdata = host_rdata;    // valid with rd_done
            REG_INCR:      prdata = incr;
            REG_WR_MASK:   prdata = {{(VRAM_DATA_W-NIBBLES){1'b0}}, wr_mask};
            REG_DISP_BASE: prdata = disp_base;
            default:       prdata = '0;
        endcase
    end

endmodule

/* verilog/vram_arbiter.sv */
// fixed priority vram arbiter, fetcher over host, with read data return routing
module vram_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    input  vram_pkg::vram_req_t   host_req,
    input  vram_pkg::vram_req_t   fetch_req,
    input  vram_pkg::vram_word_t  rd_data,
    output vram_pkg::vram_req_t   mem_req,
    output logic                  host_gnt,
    output logic                  fetch_gnt,
    output logic                  host_rvalid,
    output logic                  fetch_rvalid,
    output vram_pkg::vram_word_t  host_rdata,
    output vram_pkg::vram_word_t  fetch_rdata
);

    import vram_pkg::*;

    logic host_rd_q;    // host owned last cycle's read
    logic fetch_rd_q;   // fetcher owned last cycle's read

    // display traffic always goes first
    always_comb begin
        fetch_gnt = fetch_req.valid;
        host_gnt  = host_req.valid && !fetch_req.valid;
    end

    // host request passes when fetcher idle, its valid low means no access at all
    always_comb begin
        if (fetch_req.valid) begin
            mem_req = fetch_req;
        end else begin
            mem_req = host_req;
        end
    end

    // owner of the data coming out of the ram next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            host_rd_q  <= 1'b0;
            fetch_rd_q <= 1'b0;
        end else begin
            host_rd_q  <= host_gnt && !host_req.wr_en;
            fetch_rd_q <= fetch_gnt && !fetch_req.wr_en;
        end
    end

    assign host_rvalid  = host_rd_q;
    assign fetch_rvalid = fetch_rd_q;

    // both peers see the shared read bus
    assign host_rdata  = rd_data;
    assign fetch_rdata = rd_data;

endmodule

/* vram/vram.sv */
// 64k x 16 video ram with nibble write mask and registered read port
module vram (
    input  logic                  clk,
    input  vram_pkg::vram_req_t   mem_req,
    output vram_pkg::vram_word_t  rd_data
);

    import vram_pkg::*;

    // behavioural array, contents undefined at power up
    vram_word_t mem [0:VRAM_WORDS-1];

    // read returns the old word when a write hits the same address
    always_ff @(posedge clk) begin
        if (mem_req.valid) begin
            if (mem_req.wr_en) begin
                for (int n = 0; n < NIBBLES; n++) begin
                    if (mem_req.wr_mask[n]) begin
                        mem[mem_req.addr][4*n +: 4] <= mem_req.data[4*n +: 4];
                    end
                end
            end
            rd_data <= mem[mem_req.addr];   // one cycle read latency
        end
    end

endmodule

/* common/vram_pkg.sv */
// vram widths, request struct, apb register map and scan line length
package vram_pkg;

    localparam int VRAM_ADDR_W = 16;
    localparam int VRAM_DATA_W = 16;
    localparam int VRAM_WORDS  = 1 << VRAM_ADDR_W;
    localparam int NIBBLES     = VRAM_DATA_W / 4;    // one mask bit per nibble

    localparam int APB_ADDR_W  = 8;

    typedef logic [VRAM_ADDR_W-1:0] vram_addr_t;
    typedef logic [VRAM_DATA_W-1:0] vram_word_t;
    typedef logic [NIBBLES-1:0]     vram_mask_t;

    // one ram access, as driven by either peer
    typedef struct packed {
        logic       valid;
        logic       wr_en;
        vram_mask_t wr_mask;
        vram_addr_t addr;
        vram_word_t data;
    } vram_req_t;

    // register index, paddr[4:2]
    typedef logic [2:0] reg_sel_t;

    localparam reg_sel_t REG_WR_ADDR   = 3'd0;
    localparam reg_sel_t REG_RD_ADDR   = 3'd1;
    localparam reg_sel_t REG_DATA      = 3'd2;   // vram data port
    localparam reg_sel_t REG_INCR      = 3'd3;
    localparam reg_sel_t REG_WR_MASK   = 3'd4;
    localparam reg_sel_t REG_DISP_BASE = 3'd5;

    localparam vram_addr_t INCR_RESET    = 16'h0001;
    localparam vram_mask_t WR_MASK_RESET = 4'hf;

    // scan line
    localparam int LINE_WORDS = 16;
    localparam int LINE_CNT_W = $clog2(LINE_WORDS);

    typedef logic [LINE_CNT_W-1:0] line_cnt_t;

endpackage
